//--- rtl/axi_ic_pkg.sv
package axi_ic_pkg;

    localparam int ID_W    = 4;
    localparam int CID_W   = 4;
    localparam int SID_W   = CID_W + ID_W;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int LEN_W   = 8;
    localparam int N_MST   = 3;
    localparam int N_SLV   = 3;
    localparam int SEL_LSB = 30;     // addr[31:30] picks the slave
    localparam int FIFO_AW = 2;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } mst_ar_t;

    typedef struct packed {
        logic [SID_W-1:0]  sid;      // channel id in the upper nibble
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } slv_ar_t;

    typedef struct packed {
        logic [SID_W-1:0]  sid;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } slv_r_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } mst_r_t;

endpackage

//--- rtl/axi_fifo_sync.sv
module axi_fifo_sync #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     wr_vld,
    input  payload_t wr_din,
    input  logic     rd_rdy,
    output logic     wr_rdy,
    output logic     rd_vld,
    output payload_t rd_dout
);
    import axi_ic_pkg::*;

    payload_t           mem [1 << FIFO_AW];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               push;
    logic               pop;

    assign wr_rdy  = !count[FIFO_AW];       // msb only set when full
    assign rd_vld  = (count != '0);
    assign rd_dout = mem[rd_ptr];
    assign push    = wr_vld && wr_rdy;
    assign pop     = rd_vld && rd_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_din;
        end
    end

endmodule

//--- rtl/ar_router.sv
module ar_router (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                m_vld [axi_ic_pkg::N_MST],
    input  axi_ic_pkg::mst_ar_t m_ar  [axi_ic_pkg::N_MST],
    input  logic                s_rdy [axi_ic_pkg::N_SLV+1],
    output logic                m_rdy [axi_ic_pkg::N_MST],
    output logic                s_vld [axi_ic_pkg::N_SLV+1],
    output axi_ic_pkg::slv_ar_t s_ar  [axi_ic_pkg::N_SLV+1]
);
    import axi_ic_pkg::*;

    logic [N_MST-1:0] req    [N_SLV+1];
    logic [N_MST-1:0] gnt    [N_SLV+1];
    logic [N_MST-1:0] rr_ptr [N_SLV+1];    // one-hot, master with top priority

    // target N_SLV is the decode-miss port
    for (genvar t = 0; t < N_SLV + 1; t++) begin : g_tgt
        for (genvar i = 0; i < N_MST; i++) begin : g_mst
            assign req[t][i] = m_vld[i]
                && (m_ar[i].addr[ADDR_W-1:SEL_LSB] == (ADDR_W - SEL_LSB)'(t));
        end
    end

    always_comb begin
        logic [N_MST-1:0] upper;
        for (int t = 0; t < N_SLV + 1; t++) begin
            upper = req[t] & ~(rr_ptr[t] - 1'b1);   // at or above the pointer
            if (upper != '0) begin
                gnt[t] = upper & (~upper + 1'b1);
            end else begin
                gnt[t] = req[t] & (~req[t] + 1'b1); // wrap around
            end
        end
    end

    always_comb begin
        for (int t = 0; t < N_SLV + 1; t++) begin
            s_vld[t] = |gnt[t];
            s_ar[t]  = '0;
            for (int i = 0; i < N_MST; i++) begin
                if (gnt[t][i]) begin
                    s_ar[t].sid   = {CID_W'(i + 1), m_ar[i].id};
                    s_ar[t].addr  = m_ar[i].addr;
                    s_ar[t].len   = m_ar[i].len;
                    s_ar[t].size  = m_ar[i].size;
                    s_ar[t].burst = m_ar[i].burst;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < N_MST; i++) begin
            m_rdy[i] = 1'b0;
            for (int t = 0; t < N_SLV + 1; t++) begin
                if (gnt[t][i] && s_rdy[t]) begin
                    m_rdy[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < N_SLV + 1; t++) begin
                rr_ptr[t] <= N_MST'(1);
            end
        end else begin
            for (int t = 0; t < N_SLV + 1; t++) begin
                if (s_vld[t] && s_rdy[t]) begin
                    rr_ptr[t] <= {gnt[t][N_MST-2:0], gnt[t][N_MST-1]};  // next after winner
                end
            end
        end
    end

endmodule

//--- rtl/decerr_slave.sv
module decerr_slave (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ar_vld,
    input  axi_ic_pkg::slv_ar_t ar,
    input  logic                r_rdy,
    output logic                ar_rdy,
    output logic                r_vld,
    output axi_ic_pkg::slv_r_t  r
);
    import axi_ic_pkg::*;

    logic             busy;
    logic [LEN_W-1:0] beats_left;
    logic [SID_W-1:0] sid_q;

    assign ar_rdy = !busy;
    assign r_vld  = busy;

    assign r.sid  = sid_q;
    assign r.data = '0;
    assign r.resp = RESP_DECERR;
    assign r.last = (beats_left == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            beats_left <= '0;
        end else if (ar_vld && ar_rdy) begin
            busy       <= 1'b1;
            beats_left <= ar.len;           // arlen+1 beats to go
        end else if (r_vld && r_rdy) begin
            if (r.last) begin
                busy <= 1'b0;
            end else begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_vld && ar_rdy) begin
            sid_q <= ar.sid;
        end
    end

endmodule

//--- rtl/r_router.sv
module r_router (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               s_vld [axi_ic_pkg::N_SLV+1],
    input  axi_ic_pkg::slv_r_t s_r   [axi_ic_pkg::N_SLV+1],
    input  logic               m_rdy [axi_ic_pkg::N_MST],
    output logic               s_rdy [axi_ic_pkg::N_SLV+1],
    output logic               m_vld [axi_ic_pkg::N_MST],
    output axi_ic_pkg::mst_r_t m_r   [axi_ic_pkg::N_MST]
);
    import axi_ic_pkg::*;

    logic [N_SLV:0] req      [N_MST];
    logic [N_SLV:0] gnt      [N_MST];
    logic [N_SLV:0] rr_ptr   [N_MST];
    logic [N_SLV:0] lock_src [N_MST];
    logic           lock     [N_MST];      // burst in progress

    for (genvar m = 0; m < N_MST; m++) begin : g_mst
        for (genvar s = 0; s < N_SLV + 1; s++) begin : g_src
            assign req[m][s] = s_vld[s] && (s_r[s].sid[SID_W-1:ID_W] == CID_W'(m + 1));
        end
    end

    always_comb begin
        logic [N_SLV:0] upper;
        for (int m = 0; m < N_MST; m++) begin
            upper = req[m] & ~(rr_ptr[m] - 1'b1);
            if (lock[m]) begin
                gnt[m] = lock_src[m] & req[m];  // hold source until rlast
            end else if (upper != '0) begin
                gnt[m] = upper & (~upper + 1'b1);
            end else begin
                gnt[m] = req[m] & (~req[m] + 1'b1);
            end
        end
    end

    always_comb begin
        for (int m = 0; m < N_MST; m++) begin
            m_vld[m] = |gnt[m];
            m_r[m]   = '0;
            for (int s = 0; s < N_SLV + 1; s++) begin
                if (gnt[m][s]) begin
                    m_r[m].id   = s_r[s].sid[ID_W-1:0];   // strip channel id
                    m_r[m].data = s_r[s].data;
                    m_r[m].resp = s_r[s].resp;
                    m_r[m].last = s_r[s].last;
                end
            end
        end
        for (int s = 0; s < N_SLV + 1; s++) begin
            s_rdy[s] = 1'b0;
            for (int m = 0; m < N_MST; m++) begin
                if (gnt[m][s] && m_rdy[m]) begin
                    s_rdy[s] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int m = 0; m < N_MST; m++) begin
                lock[m]     <= 1'b0;
                lock_src[m] <= '0;
                rr_ptr[m]   <= (N_SLV + 1)'(1);
            end
        end else begin
            for (int m = 0; m < N_MST; m++) begin
                if (m_vld[m] && m_rdy[m] && m_r[m].last) begin
                    lock[m]   <= 1'b0;
                    rr_ptr[m] <= {gnt[m][N_SLV-1:0], gnt[m][N_SLV]};
                end else if (m_vld[m]) begin
                    lock[m]     <= 1'b1;
                    lock_src[m] <= gnt[m];
                end
            end
        end
    end

endmodule

//--- rtl/axi_interconnect.sv
module axi_interconnect (
    input  logic                             axi_clk,
    input  logic                             arst_n,

    input  logic [axi_ic_pkg::ID_W-1:0]      m_axi_arid    [axi_ic_pkg::N_MST],
    input  logic [axi_ic_pkg::ADDR_W-1:0]    m_axi_araddr  [axi_ic_pkg::N_MST],
    input  logic [axi_ic_pkg::LEN_W-1:0]     m_axi_arlen   [axi_ic_pkg::N_MST],
    input  logic [2:0]                       m_axi_arsize  [axi_ic_pkg::N_MST],
    input  logic [1:0]                       m_axi_arburst [axi_ic_pkg::N_MST],
    input  logic                             m_axi_arvalid [axi_ic_pkg::N_MST],
    output logic                             m_axi_arready [axi_ic_pkg::N_MST],

    output logic [axi_ic_pkg::ID_W-1:0]      m_axi_rid     [axi_ic_pkg::N_MST],
    output logic [axi_ic_pkg::DATA_W-1:0]    m_axi_rdata   [axi_ic_pkg::N_MST],
    output logic [1:0]                       m_axi_rresp   [axi_ic_pkg::N_MST],
    output logic                             m_axi_rlast   [axi_ic_pkg::N_MST],
    output logic                             m_axi_rvalid  [axi_ic_pkg::N_MST],
    input  logic                             m_axi_rready  [axi_ic_pkg::N_MST],

    output logic [axi_ic_pkg::SID_W-1:0]     s_axi_arid    [axi_ic_pkg::N_SLV],
    output logic [axi_ic_pkg::ADDR_W-1:0]    s_axi_araddr  [axi_ic_pkg::N_SLV],
    output logic [axi_ic_pkg::LEN_W-1:0]     s_axi_arlen   [axi_ic_pkg::N_SLV],
    output logic [2:0]                       s_axi_arsize  [axi_ic_pkg::N_SLV],
    output logic [1:0]                       s_axi_arburst [axi_ic_pkg::N_SLV],
    output logic                             s_axi_arvalid [axi_ic_pkg::N_SLV],
    input  logic                             s_axi_arready [axi_ic_pkg::N_SLV],

    input  logic [axi_ic_pkg::SID_W-1:0]     s_axi_rid     [axi_ic_pkg::N_SLV],
    input  logic [axi_ic_pkg::DATA_W-1:0]    s_axi_rdata   [axi_ic_pkg::N_SLV],
    input  logic [1:0]                       s_axi_rresp   [axi_ic_pkg::N_SLV],
    input  logic                             s_axi_rlast   [axi_ic_pkg::N_SLV],
    input  logic                             s_axi_rvalid  [axi_ic_pkg::N_SLV],
    output logic                             s_axi_rready  [axi_ic_pkg::N_SLV]
);
    import axi_ic_pkg::*;

    mst_ar_t m_ar_in  [N_MST];
    mst_ar_t m_ar_q   [N_MST];
    logic    m_ar_vld [N_MST];
    logic    m_ar_rdy [N_MST];

    slv_ar_t s_ar_d   [N_SLV+1];       // last entry feeds the error slave
    slv_ar_t s_ar_q   [N_SLV];
    logic    s_ar_vld [N_SLV+1];
    logic    s_ar_rdy [N_SLV+1];

    slv_r_t  s_r_in   [N_SLV];
    slv_r_t  s_r_q    [N_SLV+1];
    logic    s_r_vld  [N_SLV+1];
    logic    s_r_rdy  [N_SLV+1];

    mst_r_t  m_r_d    [N_MST];
    mst_r_t  m_r_q    [N_MST];
    logic    m_r_vld  [N_MST];
    logic    m_r_rdy  [N_MST];

    for (genvar i = 0; i < N_MST; i++) begin : g_mst
        assign m_ar_in[i] = '{id: m_axi_arid[i], addr: m_axi_araddr[i], len: m_axi_arlen[i],
                              size: m_axi_arsize[i], burst: m_axi_arburst[i]};

        axi_fifo_sync #(.payload_t(mst_ar_t)) u_fifo_ar_m (
            .clk     (axi_clk),
            .arst_n  (arst_n),
            .wr_vld  (m_axi_arvalid[i]),
            .wr_din  (m_ar_in[i]),
            .rd_rdy  (m_ar_rdy[i]),
            .wr_rdy  (m_axi_arready[i]),
            .rd_vld  (m_ar_vld[i]),
            .rd_dout (m_ar_q[i])
        );

        axi_fifo_sync #(.payload_t(mst_r_t)) u_fifo_r_m (
            .clk     (axi_clk),
            .arst_n  (arst_n),
            .wr_vld  (m_r_vld[i]),
            .wr_din  (m_r_d[i]),
            .rd_rdy  (m_axi_rready[i]),
            .wr_rdy  (m_r_rdy[i]),
            .rd_vld  (m_axi_rvalid[i]),
            .rd_dout (m_r_q[i])
        );

        assign m_axi_rid[i]   = m_r_q[i].id;
        assign m_axi_rdata[i] = m_r_q[i].data;
        assign m_axi_rresp[i] = m_r_q[i].resp;
        assign m_axi_rlast[i] = m_r_q[i].last;
    end

    for (genvar i = 0; i < N_SLV; i++) begin : g_slv
        axi_fifo_sync #(.payload_t(slv_ar_t)) u_fifo_ar_s (
            .clk     (axi_clk),
            .arst_n  (arst_n),
            .wr_vld  (s_ar_vld[i]),
            .wr_din  (s_ar_d[i]),
            .rd_rdy  (s_axi_arready[i]),
            .wr_rdy  (s_ar_rdy[i]),
            .rd_vld  (s_axi_arvalid[i]),
            .rd_dout (s_ar_q[i])
        );

        assign s_axi_arid[i]    = s_ar_q[i].sid;
        assign s_axi_araddr[i]  = s_ar_q[i].addr;
        assign s_axi_arlen[i]   = s_ar_q[i].len;
        assign s_axi_arsize[i]  = s_ar_q[i].size;
        assign s_axi_arburst[i] = s_ar_q[i].burst;

        assign s_r_in[i] = '{sid: s_axi_rid[i], data: s_axi_rdata[i], resp: s_axi_rresp[i],
                             last: s_axi_rlast[i]};

        axi_fifo_sync #(.payload_t(slv_r_t)) u_fifo_r_s (
            .clk     (axi_clk),
            .arst_n  (arst_n),
            .wr_vld  (s_axi_rvalid[i]),
            .wr_din  (s_r_in[i]),
            .rd_rdy  (s_r_rdy[i]),
            .wr_rdy  (s_axi_rready[i]),
            .rd_vld  (s_r_vld[i]),
            .rd_dout (s_r_q[i])
        );
    end

    ar_router u_ar_router (
        .clk    (axi_clk),
        .arst_n (arst_n),
        .m_vld  (m_ar_vld),
        .m_ar   (m_ar_q),
        .s_rdy  (s_ar_rdy),
        .m_rdy  (m_ar_rdy),
        .s_vld  (s_ar_vld),
        .s_ar   (s_ar_d)
    );

    decerr_slave u_decerr_slave (
        .clk    (axi_clk),
        .arst_n (arst_n),
        .ar_vld (s_ar_vld[N_SLV]),
        .ar     (s_ar_d[N_SLV]),
        .r_rdy  (s_r_rdy[N_SLV]),
        .ar_rdy (s_ar_rdy[N_SLV]),
        .r_vld  (s_r_vld[N_SLV]),
        .r      (s_r_q[N_SLV])
    );

    r_router u_r_router (
        .clk    (axi_clk),
        .arst_n (arst_n),
        .s_vld  (s_r_vld),
        .s_r    (s_r_q),
        .m_rdy  (m_r_rdy),
        .s_rdy  (s_r_rdy),
        .m_vld  (m_r_vld),
        .m_r    (m_r_d)
    );

endmodule

//--- tb/axi_interconnect_assertions.sv
module axi_interconnect_assertions (
    input logic                          axi_clk,
    input logic                          arst_n,
    input logic                          m_axi_rvalid  [axi_ic_pkg::N_MST],
    input logic                          m_axi_rready  [axi_ic_pkg::N_MST],
    input logic [axi_ic_pkg::ID_W-1:0]   m_axi_rid     [axi_ic_pkg::N_MST],
    input logic [axi_ic_pkg::DATA_W-1:0] m_axi_rdata   [axi_ic_pkg::N_MST],
    input logic [1:0]                    m_axi_rresp   [axi_ic_pkg::N_MST],
    input logic                          m_axi_rlast   [axi_ic_pkg::N_MST],
    input logic                          s_axi_arvalid [axi_ic_pkg::N_SLV],
    input logic                          s_axi_arready [axi_ic_pkg::N_SLV],
    input logic [axi_ic_pkg::SID_W-1:0]  s_axi_arid    [axi_ic_pkg::N_SLV],
    input logic [axi_ic_pkg::ADDR_W-1:0] s_axi_araddr  [axi_ic_pkg::N_SLV],
    input logic [axi_ic_pkg::LEN_W-1:0]  s_axi_arlen   [axi_ic_pkg::N_SLV],
    input logic [2:0]                    s_axi_arsize  [axi_ic_pkg::N_SLV],
    input logic [1:0]                    s_axi_arburst [axi_ic_pkg::N_SLV]
);
    import axi_ic_pkg::*;

    for (genvar i = 0; i < N_MST; i++) begin : g_mst
        a_r_hold: assert property (@(posedge axi_clk) disable iff (!arst_n)
            m_axi_rvalid[i] && !m_axi_rready[i] |=> m_axi_rvalid[i] && $stable(m_axi_rid[i])
                && $stable(m_axi_rdata[i]) && $stable(m_axi_rresp[i])
                && $stable(m_axi_rlast[i]))
            else $error("master %0d R beat changed before rready", i);
        a_r_reset: assert property (@(posedge axi_clk) !arst_n |-> !m_axi_rvalid[i])
            else $error("master %0d rvalid high in reset", i);
    end

    for (genvar i = 0; i < N_SLV; i++) begin : g_slv
        a_ar_hold: assert property (@(posedge axi_clk) disable iff (!arst_n)
            s_axi_arvalid[i] && !s_axi_arready[i] |=> s_axi_arvalid[i]
                && $stable(s_axi_arid[i]) && $stable(s_axi_araddr[i]) && $stable(s_axi_arlen[i])
                && $stable(s_axi_arsize[i]) && $stable(s_axi_arburst[i]))
            else $error("slave %0d AR request changed before arready", i);
        a_ar_reset: assert property (@(posedge axi_clk) !arst_n |-> !s_axi_arvalid[i])
            else $error("slave %0d arvalid high in reset", i);
    end

endmodule

bind axi_interconnect axi_interconnect_assertions u_assertions (.*);

//--- tb/tb_axi_interconnect.sv
module tb_axi_interconnect;
    import axi_ic_pkg::*;

    localparam int         PERIOD     = 40;
    localparam int         N_PAT      = 18;
    localparam int         MAX_CYCLES = 4000;
    localparam int         SEED       = 32'h5ab5_9c30;
    localparam logic [2:0] AR_SIZE    = 3'd2;    // 4-byte beats
    localparam logic [1:0] AR_BURST   = 2'b01;   // incr

    logic              axi_clk;
    logic              arst_n;
    logic [ID_W-1:0]   m_axi_arid    [N_MST];
    logic [ADDR_W-1:0] m_axi_araddr  [N_MST];
    logic [LEN_W-1:0]  m_axi_arlen   [N_MST];
    logic [2:0]        m_axi_arsize  [N_MST];
    logic [1:0]        m_axi_arburst [N_MST];
    logic              m_axi_arvalid [N_MST];
    logic              m_axi_arready [N_MST];
    logic [ID_W-1:0]   m_axi_rid     [N_MST];
    logic [DATA_W-1:0] m_axi_rdata   [N_MST];
    logic [1:0]        m_axi_rresp   [N_MST];
    logic              m_axi_rlast   [N_MST];
    logic              m_axi_rvalid  [N_MST];
    logic              m_axi_rready  [N_MST];
    logic [SID_W-1:0]  s_axi_arid    [N_SLV];
    logic [ADDR_W-1:0] s_axi_araddr  [N_SLV];
    logic [LEN_W-1:0]  s_axi_arlen   [N_SLV];
    logic [2:0]        s_axi_arsize  [N_SLV];
    logic [1:0]        s_axi_arburst [N_SLV];
    logic              s_axi_arvalid [N_SLV];
    logic              s_axi_arready [N_SLV];
    logic [SID_W-1:0]  s_axi_rid     [N_SLV];
    logic [DATA_W-1:0] s_axi_rdata   [N_SLV];
    logic [1:0]        s_axi_rresp   [N_SLV];
    logic              s_axi_rlast   [N_SLV];
    logic              s_axi_rvalid  [N_SLV];
    logic              s_axi_rready  [N_SLV];

    logic [51:0]       pat_mem  [N_PAT];
    int                mst_list [N_MST][N_PAT];
    int                mst_cnt  [N_MST];
    int                ar_pos   [N_MST];
    bit                ar_fire  [N_MST];
    int                rx_idx   [N_MST];     // burst in flight, -1 when idle
    int                rx_beat  [N_MST];
    bit                rx_done  [N_PAT];
    bit                slv_seen [N_PAT];
    int                done_cnt;
    int                cycles;
    logic [ADDR_W-1:0] sl_addr  [N_SLV][N_PAT];
    logic [LEN_W-1:0]  sl_len   [N_SLV][N_PAT];
    logic [SID_W-1:0]  sl_sid   [N_SLV][N_PAT];
    int                sl_wr    [N_SLV];
    int                sl_rd    [N_SLV];
    int                sl_beat  [N_SLV];
    bit                sr_fire  [N_SLV];
    integer            seed;

    axi_interconnect dut (.*);

    initial begin
        axi_clk = 1'b0;
        forever #(PERIOD / 2) axi_clk = ~axi_clk;
    end

    function automatic int master_of(input int p);
        return int'(pat_mem[p][51:48]);
    endfunction

    function automatic logic [ID_W-1:0] id_of(input int p);
        return pat_mem[p][47:44];
    endfunction

    function automatic logic [ADDR_W-1:0] addr_of(input int p);
        return pat_mem[p][43:12];
    endfunction

    function automatic logic [LEN_W-1:0] len_of(input int p);
        return pat_mem[p][11:4];
    endfunction

    function automatic logic [1:0] resp_of(input int p);
        return pat_mem[p][1:0];
    endfunction

    function automatic logic [DATA_W-1:0] expected_data(input int p, input int beat);
        if (resp_of(p) == RESP_DECERR) begin
            return '0;
        end
        return addr_of(p) + beat;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAILED %s expected 0x%0h actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    task automatic take_beat(input int m);
        int p;
        int b;
        if (rx_idx[m] < 0) begin
            for (int q = 0; q < N_PAT; q++) begin
                if (master_of(q) == m && id_of(q) == m_axi_rid[m] && !rx_done[q]) begin
                    rx_idx[m] = q;
                end
            end
            if (rx_idx[m] < 0) begin
                abort_run($sformatf("master %0d received a beat with unexpected id 0x%0h",
                                    m, m_axi_rid[m]));
            end
            rx_beat[m] = 0;
        end
        p = rx_idx[m];
        b = rx_beat[m];
        check_value($sformatf("pattern %0d beat %0d rid", p, b), id_of(p), m_axi_rid[m]);
        check_value($sformatf("pattern %0d beat %0d rdata", p, b), expected_data(p, b),
                    m_axi_rdata[m]);
        check_value($sformatf("pattern %0d beat %0d rresp", p, b), resp_of(p), m_axi_rresp[m]);
        check_value($sformatf("pattern %0d beat %0d rlast", p, b), b == len_of(p),
                    m_axi_rlast[m]);
        if (b == len_of(p)) begin
            rx_done[p] = 1'b1;
            rx_idx[m]  = -1;
            done_cnt   = done_cnt + 1;
        end else begin
            rx_beat[m] = b + 1;
        end
    endtask

    task automatic accept_ar(input int s);
        int p;
        p = -1;
        for (int q = 0; q < N_PAT; q++) begin
            if (addr_of(q) == s_axi_araddr[s] && !slv_seen[q]) begin
                p = q;
            end
        end
        if (p < 0) begin
            abort_run($sformatf("slave %0d received an AR for unknown address 0x%0h",
                                s, s_axi_araddr[s]));
        end
        slv_seen[p] = 1'b1;
        check_value($sformatf("pattern %0d target slave", p), addr_of(p) >> SEL_LSB, s);
        check_value($sformatf("pattern %0d arid", p), ((master_of(p) + 1) << ID_W) | id_of(p),
                    s_axi_arid[s]);
        check_value($sformatf("pattern %0d arlen", p), len_of(p), s_axi_arlen[s]);
        check_value($sformatf("pattern %0d arsize", p), AR_SIZE, s_axi_arsize[s]);
        check_value($sformatf("pattern %0d arburst", p), AR_BURST, s_axi_arburst[s]);
        sl_addr[s][sl_wr[s]] = s_axi_araddr[s];
        sl_len[s][sl_wr[s]]  = s_axi_arlen[s];
        sl_sid[s][sl_wr[s]]  = s_axi_arid[s];
        sl_wr[s]             = sl_wr[s] + 1;
    endtask

    // stable window, inputs change only at posedge plus 2
    task automatic sample_handshakes();
        for (int m = 0; m < N_MST; m++) begin
            if (m_axi_arvalid[m] && m_axi_arready[m]) begin
                ar_fire[m] = 1'b1;
            end
            if (m_axi_rvalid[m] && m_axi_rready[m]) begin
                take_beat(m);
            end
        end
        for (int s = 0; s < N_SLV; s++) begin
            if (s_axi_arvalid[s] && s_axi_arready[s]) begin
                accept_ar(s);
            end
            if (s_axi_rvalid[s] && s_axi_rready[s]) begin
                sr_fire[s] = 1'b1;
            end
        end
    endtask

    task automatic drive_inputs();
        int p;
        for (int m = 0; m < N_MST; m++) begin
            if (!m_axi_arvalid[m] || ar_fire[m]) begin
                ar_fire[m]       = 1'b0;
                m_axi_arvalid[m] = 1'b0;
                if (ar_pos[m] < mst_cnt[m] && ($random(seed) & 3) != 0) begin
                    p                = mst_list[m][ar_pos[m]];
                    ar_pos[m]        = ar_pos[m] + 1;
                    m_axi_arid[m]    = id_of(p);
                    m_axi_araddr[m]  = addr_of(p);
                    m_axi_arlen[m]   = len_of(p);
                    m_axi_arsize[m]  = AR_SIZE;
                    m_axi_arburst[m] = AR_BURST;
                    m_axi_arvalid[m] = 1'b1;
                end
            end
            m_axi_rready[m] = ($random(seed) & 3) != 0;   // stalls about one cycle in four
        end
        for (int s = 0; s < N_SLV; s++) begin
            s_axi_arready[s] = ($random(seed) & 3) != 0;
            if (sr_fire[s]) begin
                sr_fire[s]      = 1'b0;
                s_axi_rvalid[s] = 1'b0;
                if (sl_beat[s] == sl_len[s][sl_rd[s]]) begin
                    sl_rd[s]   = sl_rd[s] + 1;
                    sl_beat[s] = 0;
                end else begin
                    sl_beat[s] = sl_beat[s] + 1;
                end
            end
            if (!s_axi_rvalid[s] && sl_rd[s] < sl_wr[s] && ($random(seed) & 1) != 0) begin
                s_axi_rid[s]    = sl_sid[s][sl_rd[s]];            // sid echoed back
                s_axi_rdata[s]  = sl_addr[s][sl_rd[s]] + sl_beat[s];
                s_axi_rresp[s]  = RESP_OKAY;
                s_axi_rlast[s]  = (sl_beat[s] == sl_len[s][sl_rd[s]]);
                s_axi_rvalid[s] = 1'b1;
            end
        end
    endtask

    task automatic init_inputs();
        for (int m = 0; m < N_MST; m++) begin
            m_axi_arid[m]    = '0;
            m_axi_araddr[m]  = '0;
            m_axi_arlen[m]   = '0;
            m_axi_arsize[m]  = '0;
            m_axi_arburst[m] = '0;
            m_axi_arvalid[m] = 1'b0;
            m_axi_rready[m]  = 1'b0;
            mst_cnt[m]       = 0;
            ar_pos[m]        = 0;
            ar_fire[m]       = 1'b0;
            rx_idx[m]        = -1;
            rx_beat[m]       = 0;
        end
        for (int s = 0; s < N_SLV; s++) begin
            s_axi_arready[s] = 1'b0;
            s_axi_rid[s]     = '0;
            s_axi_rdata[s]   = '0;
            s_axi_rresp[s]   = '0;
            s_axi_rlast[s]   = 1'b0;
            s_axi_rvalid[s]  = 1'b0;
            sl_wr[s]         = 0;
            sl_rd[s]         = 0;
            sl_beat[s]       = 0;
            sr_fire[s]       = 1'b0;
        end
    endtask

    initial begin
        seed     = SEED;
        arst_n   = 1'b0;
        done_cnt = 0;
        init_inputs();
        $readmemh("tb/read_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[N_PAT-1])) begin
            abort_run("the pattern file holds fewer reads than expected");
        end
        for (int p = 0; p < N_PAT; p++) begin
            rx_done[p]  = 1'b0;
            slv_seen[p] = 1'b0;
            if (master_of(p) >= N_MST) begin
                abort_run($sformatf("pattern %0d names a master that does not exist", p));
            end
            mst_list[master_of(p)][mst_cnt[master_of(p)]] = p;
            mst_cnt[master_of(p)] = mst_cnt[master_of(p)] + 1;
        end

        repeat (10) @(posedge axi_clk);
        #2;
        arst_n = 1'b1;
        drive_inputs();

        cycles = 0;
        while (done_cnt < N_PAT && cycles < MAX_CYCLES) begin
            @(negedge axi_clk);
            sample_handshakes();
            @(posedge axi_clk);
            #2;
            drive_inputs();
            cycles = cycles + 1;
        end

        if (done_cnt < N_PAT) begin
            abort_run($sformatf("timeout waiting for read bursts, %0d of %0d complete",
                                done_cnt, N_PAT));
        end else begin
            // idle cycles catch late or duplicated beats
            repeat (20) begin
                @(negedge axi_clk);
                sample_handshakes();
                @(posedge axi_clk);
                #2;
                drive_inputs();
            end
            for (int p = 0; p < N_PAT; p++) begin
                check_value($sformatf("pattern %0d AR seen at a slave", p),
                            resp_of(p) == RESP_OKAY, slv_seen[p]);
            end
            for (int s = 0; s < N_SLV; s++) begin
                check_value($sformatf("slave %0d bursts returned", s), sl_wr[s], sl_rd[s]);
            end
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- list.f
rtl/axi_ic_pkg.sv
rtl/axi_fifo_sync.sv
rtl/ar_router.sv
rtl/decerr_slave.sv
rtl/r_router.sv
rtl/axi_interconnect.sv
tb/axi_interconnect_assertions.sv
tb/tb_axi_interconnect.sv

//--- Bender.yml
package:
  name: axi_interconnect

sources:
  - rtl/axi_ic_pkg.sv
  - rtl/axi_fifo_sync.sv
  - rtl/ar_router.sv
  - rtl/decerr_slave.sv
  - rtl/r_router.sv
  - rtl/axi_interconnect.sv
  - target: test
    files:
      - tb/axi_interconnect_assertions.sv
      - tb/tb_axi_interconnect.sv

//--- tb/read_patterns.txt
// each line holds master, id, address, length and expected response in hex
// response 0 is OKAY and 3 is DECERR, address bits 31:30 equal to 3 are unmapped
0_1_40000000_03_0
0_2_00000100_07_0
0_3_80000200_07_0
0_4_c0000010_02_3
0_5_00000400_00_0
0_6_40000300_0f_0
1_1_40001000_03_0
1_7_00001100_01_0
1_8_80001200_05_0
1_9_c0001010_00_3
1_a_40001300_02_0
1_b_80001400_0b_0
2_1_40002000_03_0
2_c_00002100_02_0
2_d_80002200_01_0
2_e_c0002010_04_3
2_f_00002300_09_0
2_0_80002400_00_0
